// File: hw/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  // major opcodes, bits [6:0] of the instruction word
  typedef enum logic [6:0] {
    opc_op_imm   = 7'b0010011, // addi, slti, shifts by immediate
    opc_op       = 7'b0110011, // register-register alu
    opc_load     = 7'b0000011,
    opc_store    = 7'b0100011,
    opc_jal      = 7'b1101111,
    opc_jalr     = 7'b1100111,
    opc_auipc    = 7'b0010111,
    opc_lui      = 7'b0110111,
    opc_branch   = 7'b1100011,
    opc_system   = 7'b1110011, // csr access, ecall, ebreak, mret
    opc_misc_mem = 7'b0001111  // fence, fence.i
  } opcode_e;

  typedef logic [2:0] funct3_t;

  localparam funct3_t f3_add_sub     = 3'b000; // op: add or sub by funct7
  localparam funct3_t f3_slt         = 3'b010;
  localparam funct3_t f3_sltu        = 3'b011;
  localparam funct3_t f3_shift_right = 3'b101; // srl/sra, srli/srai
  localparam funct3_t f3_sb          = 3'b000; // byte store
  localparam funct3_t f3_sh          = 3'b001; // half store, sw otherwise
  localparam funct3_t f3_priv        = 3'b000; // ecall, ebreak, mret
  localparam funct3_t f3_csrrw       = 3'b001;
  localparam funct3_t f3_csrrs       = 3'b010;
  localparam funct3_t f3_fencei      = 3'b001;

  typedef enum logic [2:0] {
    csr_op_none   = 3'b000,
    csr_op_mret   = 3'b001,
    csr_op_ecall  = 3'b010,
    csr_op_ebreak = 3'b011,
    csr_op_write  = 3'b100  // csrrw / csrrs
  } csr_op_e;

endpackage

`default_nettype wire

// File: hw/exec_ctrl_pkg.sv
`default_nettype none

package exec_ctrl_pkg;

  typedef struct packed {
    rv_isa_pkg::opcode_e opcode;
    rv_isa_pkg::funct3_t funct3;
    logic [31:0]         imm;       // holds funct7 for op
    logic [31:0]         pc;
    logic [31:0]         rs1_value;
    logic [31:0]         rs2_value;
    logic [31:0]         csr_rdata;
  } issue_t;

  // top bit set selects a branch compare
  typedef enum logic [3:0] {
    alu_add  = 4'b0000,
    alu_sll  = 4'b0001,
    alu_slt  = 4'b0010,
    alu_sltu = 4'b0011,
    alu_xor  = 4'b0100,
    alu_sr   = 4'b0101, // logical or arithmetic by arith_shift
    alu_or   = 4'b0110,
    alu_and  = 4'b0111,
    alu_eq   = 4'b1000,
    alu_ne   = 4'b1001,
    alu_lt   = 4'b1100,
    alu_ge   = 4'b1101,
    alu_ltu  = 4'b1110,
    alu_geu  = 4'b1111
  } alu_op_e;

  typedef enum logic [1:0] {
    sel_alu = 2'b00,
    sel_mem = 2'b01,
    sel_csr = 2'b10
  } result_sel_e;

  typedef struct packed {
    alu_op_e             alu_op;
    logic                sub;           // adder subtracts for sub and compares
    logic                arith_shift;
    logic [31:0]         alu_a;
    logic [31:0]         alu_b;
    logic [31:0]         target_base;   // csr_rdata for all system ops
    logic [31:0]         target_offset;
    logic                jump;          // jal, jalr
    logic                trap_return;   // ecall, ebreak, mret
    logic                branch;
    logic                reg_wen;
    result_sel_e         result_sel;
    logic                mem_read;
    logic                mem_write;
    logic [3:0]          wmask;
    rv_isa_pkg::funct3_t load_kind;
    logic [31:0]         store_data;
    rv_isa_pkg::csr_op_e csr_op;
    logic                csr_write;
    logic                fencei;
  } exec_ctrl_t;

  typedef struct packed {
    logic                read;
    logic                write;
    logic [31:0]         addr;
    logic [31:0]         wdata;
    logic [3:0]          wmask;
    rv_isa_pkg::funct3_t load_kind;
  } mem_req_t;

  typedef struct packed {
    logic                write;
    rv_isa_pkg::csr_op_e op;
    logic [31:0]         wdata;
  } csr_req_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] target;
  } redirect_t;

  typedef struct packed {
    logic        reg_wen;
    result_sel_e result_sel;
    logic [31:0] rd_value;
    mem_req_t    mem;
    csr_req_t    csr;
    redirect_t   redirect;
    logic        fencei;
  } exec_result_t;

endpackage

`default_nettype wire

// File: hw/stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
  parameter type payload_t = logic
) (
  input  wire logic     clock,
  input  wire logic     reset,
  input  wire logic     load,    // capture strobe
  input  wire payload_t data,
  output logic          valid,   // one cycle after load
  output payload_t      q
);

  always_ff @(posedge clock) begin
    if (reset) begin
      valid <= 1'b0;
      q     <= '0;           // payload also cleared
    end else begin
      valid <= load;         // one-cycle pulse
      if (load) begin
        q <= data;           // held until next strobe
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/exec_ctrl_decode.sv
`timescale 1ns/1ps
`default_nettype none

module exec_ctrl_decode (
  input  wire logic                 clock,
  input  wire logic                 reset,
  input  wire logic                 decode_valid,
  input  wire exec_ctrl_pkg::issue_t issue,
  output exec_ctrl_pkg::exec_ctrl_t ctrl,
  output logic                      ctrl_valid
);

  import rv_isa_pkg::*;
  import exec_ctrl_pkg::*;

  issue_t     iss;      // registered packet
  logic [7:0] f3_hot;   // one-hot funct3
  logic       is_op_imm;
  logic       is_op;
  logic       is_load;
  logic       is_store;
  logic       is_jal;
  logic       is_jalr;
  logic       is_auipc;
  logic       is_lui;
  logic       is_branch;
  logic       is_system;
  logic       is_misc_mem;
  logic       is_alu;   // op or op-imm

  stage_reg #(
    .payload_t(issue_t)
  ) issue_reg (
    .clock(clock),
    .reset(reset),
    .load (decode_valid),
    .data (issue),
    .valid(ctrl_valid),
    .q    (iss)
  );

  // instruction classes
  assign is_op_imm   = iss.opcode == opc_op_imm;
  assign is_op       = iss.opcode == opc_op;
  assign is_load     = iss.opcode == opc_load;
  assign is_store    = iss.opcode == opc_store;
  assign is_jal      = iss.opcode == opc_jal;
  assign is_jalr     = iss.opcode == opc_jalr;
  assign is_auipc    = iss.opcode == opc_auipc;
  assign is_lui      = iss.opcode == opc_lui;
  assign is_branch   = iss.opcode == opc_branch;
  assign is_system   = iss.opcode == opc_system;
  assign is_misc_mem = iss.opcode == opc_misc_mem;
  assign is_alu      = is_op | is_op_imm;
  assign f3_hot      = 8'b1 << iss.funct3;

  always_comb begin
    ctrl = '0;

    // funct3 maps straight onto the alu op
    if (is_alu) begin
      ctrl.alu_op = alu_op_e'({1'b0, iss.funct3});
    end else if (is_branch) begin
      ctrl.alu_op = alu_op_e'({1'b1, iss.funct3});
    end else if (is_system && f3_hot[f3_csrrs]) begin
      ctrl.alu_op = alu_or;                       // rs1 | csr value
    end else begin
      ctrl.alu_op = alu_add;
    end
    ctrl.sub = (is_alu && (f3_hot[f3_slt] || f3_hot[f3_sltu])) || is_branch ||
               (is_op && f3_hot[f3_add_sub] && iss.imm[5]); // compares subtract
    ctrl.arith_shift = f3_hot[f3_shift_right] &&
                       ((is_op && iss.imm[5]) || (is_op_imm && iss.imm[10]));

    // operands
    if (is_jal || is_jalr || is_auipc) begin
      ctrl.alu_a = iss.pc;                        // link / auipc base
    end else if (is_lui) begin
      ctrl.alu_a = 32'd0;
    end else begin
      ctrl.alu_a = iss.rs1_value;
    end
    if (is_op_imm || is_load || is_store || is_auipc || is_lui) begin
      ctrl.alu_b = iss.imm;
    end else if (is_jal || is_jalr) begin
      ctrl.alu_b = 32'd4;                         // return address pc + 4
    end else if (is_system && f3_hot[f3_csrrw]) begin
      ctrl.alu_b = 32'd0;                         // passes rs1 through
    end else if (is_system && f3_hot[f3_csrrs]) begin
      ctrl.alu_b = iss.csr_rdata;
    end else begin
      ctrl.alu_b = iss.rs2_value;
    end

    // redirect
    if (is_system) begin
      ctrl.target_base = iss.csr_rdata;           // mepc or mtvec and the csr rd value
    end else if (is_jalr) begin
      ctrl.target_base = iss.rs1_value;
    end else begin
      ctrl.target_base = iss.pc;
    end
    ctrl.target_offset = (is_jal || is_jalr || is_branch) ? iss.imm : 32'd0;
    ctrl.jump          = is_jal || is_jalr;
    ctrl.trap_return   = is_system && f3_hot[f3_priv];
    ctrl.branch        = is_branch;

    // write-back
    ctrl.reg_wen = is_alu || is_load || is_jal || is_jalr || is_auipc || is_lui ||
                   is_system;                     // no store, branch, fence
    if (is_load) begin
      ctrl.result_sel = sel_mem;
    end else if (is_system) begin
      ctrl.result_sel = sel_csr;
    end else begin
      ctrl.result_sel = sel_alu;
    end

    // memory request
    ctrl.mem_read  = is_load;
    ctrl.mem_write = is_store;
    if (is_store) begin
      ctrl.wmask      = f3_hot[f3_sb] ? 4'b0001 : f3_hot[f3_sh] ? 4'b0011 : 4'b1111;
      ctrl.store_data = iss.rs2_value;
    end
    if (is_load) begin
      ctrl.load_kind = iss.funct3;                // sign handling is downstream
    end

    // csr and system
    if (is_system && f3_hot[f3_priv]) begin
      ctrl.csr_op = iss.imm[1] ? csr_op_mret : iss.imm[0] ? csr_op_ebreak : csr_op_ecall;
    end else if (is_system && (f3_hot[f3_csrrw] || f3_hot[f3_csrrs])) begin
      ctrl.csr_op = csr_op_write;
    end else begin
      ctrl.csr_op = csr_op_none;
    end
    ctrl.csr_write = is_system;                   // traps update csrs too
    ctrl.fencei    = is_misc_mem && f3_hot[f3_fencei];
  end

endmodule

`default_nettype wire

// File: hw/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
  input  wire exec_ctrl_pkg::exec_ctrl_t ctrl,
  output logic [31:0]                    alu_result,
  output exec_ctrl_pkg::redirect_t       redirect
);

  import exec_ctrl_pkg::*;

  logic [31:0] operand_b;      // b inverted when subtracting
  logic [32:0] sum_ext;        // with carry out
  logic [31:0] sum;
  logic        carry;
  logic        equal;
  logic        less_signed;
  logic        less_unsigned;
  logic [4:0]  shamt;
  logic [31:0] shift_right;
  logic        taken;          // branch compare holds
  logic [31:0] target_sum;

  // shared adder computes a - b as a + ~b + 1
  assign operand_b = ctrl.sub ? ~ctrl.alu_b : ctrl.alu_b;
  assign sum_ext   = {1'b0, ctrl.alu_a} + {1'b0, operand_b} + {32'd0, ctrl.sub};
  assign sum       = sum_ext[31:0];
  assign carry     = sum_ext[32];

  // compare flags valid only with sub set
  assign equal         = sum == 32'd0;
  assign less_unsigned = ~carry;                   // borrow out
  assign less_signed   = (ctrl.alu_a[31] != ctrl.alu_b[31]) ? ctrl.alu_a[31] : sum[31];

  assign shamt       = ctrl.alu_b[4:0];
  assign shift_right = ctrl.arith_shift ? 32'($signed(ctrl.alu_a) >>> shamt) :
                                          ctrl.alu_a >> shamt;

  always_comb begin
    case (ctrl.alu_op)
      alu_add:  alu_result = sum;
      alu_sll:  alu_result = ctrl.alu_a << shamt;
      alu_slt:  alu_result = {31'd0, less_signed};
      alu_sltu: alu_result = {31'd0, less_unsigned};
      alu_xor:  alu_result = ctrl.alu_a ^ ctrl.alu_b;
      alu_sr:   alu_result = shift_right;
      alu_or:   alu_result = ctrl.alu_a | ctrl.alu_b;
      alu_and:  alu_result = ctrl.alu_a & ctrl.alu_b;
      default:  alu_result = sum;                  // branch ops, not used
    endcase
  end

  always_comb begin
    case (ctrl.alu_op)
      alu_eq:  taken = equal;
      alu_ne:  taken = ~equal;
      alu_lt:  taken = less_signed;
      alu_ge:  taken = ~less_signed;
      alu_ltu: taken = less_unsigned;
      alu_geu: taken = ~less_unsigned;
      default: taken = 1'b0;
    endcase
  end

  assign target_sum = ctrl.target_base + ctrl.target_offset;

  assign redirect.valid = ctrl.jump | ctrl.trap_return | (ctrl.branch & taken);
  // jal offsets are always even so masking on jump only changes jalr
  assign redirect.target = ctrl.trap_return ? ctrl.target_base :
                           {target_sum[31:1], target_sum[0] & ~ctrl.jump};

endmodule

`default_nettype wire

// File: hw/result_stage.sv
`timescale 1ns/1ps
`default_nettype none

module result_stage (
  input  wire logic                     clock,
  input  wire logic                     reset,
  input  wire logic                     ctrl_valid,
  input  wire exec_ctrl_pkg::exec_ctrl_t ctrl,
  input  wire logic [31:0]              alu_result,
  input  wire exec_ctrl_pkg::redirect_t  redirect,
  output logic                          result_valid,
  output exec_ctrl_pkg::exec_result_t   result
);

  import exec_ctrl_pkg::*;

  exec_result_t next;   // packet being assembled
  logic         mem_access;

  assign mem_access = ctrl.mem_read | ctrl.mem_write;

  always_comb begin
    next            = '0;
    next.reg_wen    = ctrl.reg_wen;
    next.result_sel = ctrl.result_sel;
    // csr value rides on target_base for system ops
    next.rd_value   = (ctrl.result_sel == sel_csr) ? ctrl.target_base : alu_result;

    next.mem.read      = ctrl.mem_read;
    next.mem.write     = ctrl.mem_write;
    next.mem.addr      = mem_access ? alu_result : 32'd0;     // rs1 + imm
    next.mem.wdata     = ctrl.mem_write ? ctrl.store_data : 32'd0;
    next.mem.wmask     = ctrl.mem_write ? ctrl.wmask : 4'd0;
    next.mem.load_kind = ctrl.load_kind;

    next.csr.write = ctrl.csr_write;
    next.csr.op    = ctrl.csr_op;
    next.csr.wdata = ctrl.csr_write ? alu_result : 32'd0;     // rs1 or rs1 | csr

    next.redirect = redirect;
    next.fencei   = ctrl.fencei;
  end

  stage_reg #(
    .payload_t(exec_result_t)
  ) result_reg (
    .clock(clock),
    .reset(reset),
    .load (ctrl_valid),
    .data (next),
    .valid(result_valid),
    .q    (result)
  );

endmodule

`default_nettype wire

// File: hw/exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module exec_top (
  input  wire logic                   clock,
  input  wire logic                   reset,
  input  wire logic                   decode_valid,  // one-cycle strobe
  input  wire exec_ctrl_pkg::issue_t   issue,
  output logic                        result_valid,  // two cycles after strobe
  output exec_ctrl_pkg::exec_result_t result
);

  import exec_ctrl_pkg::*;

  exec_ctrl_t  ctrl;
  logic        ctrl_valid;
  logic [31:0] alu_result;
  redirect_t   redirect;

  exec_ctrl_decode decode_inst (
    .clock       (clock),
    .reset       (reset),
    .decode_valid(decode_valid),
    .issue       (issue),
    .ctrl        (ctrl),
    .ctrl_valid  (ctrl_valid)
  );

  // purely combinational between the two registers
  exec_unit exec_inst (
    .ctrl      (ctrl),
    .alu_result(alu_result),
    .redirect  (redirect)
  );

  result_stage result_inst (
    .clock       (clock),
    .reset       (reset),
    .ctrl_valid  (ctrl_valid),
    .ctrl        (ctrl),
    .alu_result  (alu_result),
    .redirect    (redirect),
    .result_valid(result_valid),
    .result      (result)
  );

endmodule

`default_nettype wire

// File: testbench/exec_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module exec_asserts (
  input wire logic                      clock,
  input wire logic                      reset,
  input wire logic                      ctrl_valid,
  input wire logic                      result_valid,
  input wire exec_ctrl_pkg::exec_ctrl_t ctrl,
  input wire exec_ctrl_pkg::redirect_t  redirect
);

  int unsigned failures = 0;   // failed assertion count

  // result stage adds exactly one cycle
  result_follows_ctrl: assert property (@(posedge clock) disable iff (reset)
    result_valid == $past(ctrl_valid))
    else begin
      $error("result_valid is not ctrl_valid delayed by one cycle");
      failures++;
    end

  reset_clears_valid: assert property (@(posedge clock) reset |=> !result_valid)
    else begin
      $error("result_valid high during reset");
      failures++;
    end

  // jalr clears bit 0 and jal offsets are even
  jump_target_even: assert property (@(posedge clock) disable iff (reset)
    (ctrl_valid && ctrl.jump) |-> !redirect.target[0])
    else begin
      $error("odd jump target");
      failures++;
    end

endmodule

bind exec_top exec_asserts exec_asserts_inst (
  .clock       (clock),
  .reset       (reset),
  .ctrl_valid  (ctrl_valid),
  .result_valid(result_valid),
  .ctrl        (ctrl),
  .redirect    (redirect)
);

`default_nettype wire

// File: testbench/exec_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exec_tb;

  import rv_isa_pkg::*;
  import exec_ctrl_pkg::*;

  localparam int reset_cycles = 8;

  logic         clock;
  logic         reset;
  logic         decode_valid;
  issue_t       issue;
  logic         result_valid;
  exec_result_t result;

  issue_t       stim_q[$];     // stimulus table
  exec_result_t expect_q[$];   // expected packet per row
  exec_result_t care_q[$];     // bits the ISA defines
  string        name_q[$];
  int           num_items = 0;

  exec_top exec_top_inst (
    .clock       (clock),
    .reset       (reset),
    .decode_valid(decode_valid),
    .issue       (issue),
    .result_valid(result_valid),
    .result      (result)
  );

  initial clock = 1'b0;
  always #20 clock = ~clock;   // 40 ns period

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_result(input string name, input exec_result_t exp,
                              input exec_result_t care, input exec_result_t act);
    if ((act & care) !== (exp & care)) begin
      stop_on_error($sformatf("Error: %s expected %h actual %h", name,
                              exp & care, act & care));
    end
  endtask

  task automatic check_valid(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_on_error($sformatf("Error: %s result_valid expected %b actual %b", name, exp, act));
    end
  endtask

  // rv32i alu rules with sub and sra by funct7 bit
  function automatic logic [31:0] alu_ref(input funct3_t f3, input logic [31:0] a,
                                          input logic [31:0] b, input logic sub,
                                          input logic sra);
    case (f3)
      3'd0:    return sub ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'd0, $signed(a) < $signed(b)};
      3'd3:    return {31'd0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return sra ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_ref(input funct3_t f3, input logic [31:0] a,
                                      input logic [31:0] b);
    case (f3)
      3'd0:    return a == b;                  // beq
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b); // blt
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;                   // bltu
      3'd7:    return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic exec_result_t model_result(input issue_t i);
    exec_result_t r;
    logic [31:0]  addr;
    r    = '0;
    addr = i.rs1_value + i.imm;               // loads, stores, jalr
    r.reg_wen    = !(i.opcode inside {opc_store, opc_branch, opc_misc_mem});
    r.result_sel = (i.opcode == opc_load) ? sel_mem :
                   (i.opcode == opc_system) ? sel_csr : sel_alu;
    case (i.opcode)
      opc_op:     r.rd_value = alu_ref(i.funct3, i.rs1_value, i.rs2_value, i.imm[5], i.imm[5]);
      opc_op_imm: r.rd_value = alu_ref(i.funct3, i.rs1_value, i.imm, 1'b0, i.imm[10]);
      opc_lui:    r.rd_value = i.imm;
      opc_auipc:  r.rd_value = i.pc + i.imm;
      opc_load: begin
        r.rd_value      = addr;               // address until data returns
        r.mem.read      = 1'b1;
        r.mem.addr      = addr;
        r.mem.load_kind = i.funct3;
      end
      opc_store: begin
        r.mem.write = 1'b1;
        r.mem.addr  = addr;
        r.mem.wdata = i.rs2_value;
        r.mem.wmask = (i.funct3 == 3'd0) ? 4'b0001 : (i.funct3 == 3'd1) ? 4'b0011 : 4'b1111;
      end
      opc_jal: begin
        r.rd_value = i.pc + 32'd4;
        r.redirect = '{valid: 1'b1, target: i.pc + i.imm};
      end
      opc_jalr: begin
        r.rd_value = i.pc + 32'd4;
        r.redirect = '{valid: 1'b1, target: addr & ~32'd1};
      end
      opc_branch: begin
        r.redirect.valid  = branch_ref(i.funct3, i.rs1_value, i.rs2_value);
        r.redirect.target = i.pc + i.imm;
      end
      opc_system: begin
        r.rd_value  = i.csr_rdata;
        r.csr.write = 1'b1;
        if (i.funct3 == 3'd0) begin
          r.csr.op   = (i.imm[11:0] == 12'h302) ? csr_op_mret :
                       (i.imm[11:0] == 12'h001) ? csr_op_ebreak : csr_op_ecall;
          r.redirect = '{valid: 1'b1, target: i.csr_rdata}; // mtvec or mepc
        end else begin
          r.csr.op    = csr_op_write;
          r.csr.wdata = (i.funct3 == 3'd1) ? i.rs1_value : i.rs1_value | i.csr_rdata;
        end
      end
      opc_misc_mem: r.fencei = i.funct3 == 3'd1;
      default: ;
    endcase
    return r;
  endfunction

  // fields the ISA leaves open are not compared
  function automatic exec_result_t care_mask(input exec_result_t e);
    exec_result_t m;
    m = '1;
    if (!e.reg_wen) m.rd_value = '0;
    if (!e.redirect.valid) m.redirect.target = '0;
    if (e.csr.op != csr_op_write) m.csr.wdata = '0;
    return m;
  endfunction

  task automatic add_item(input string name, input opcode_e opcode, input funct3_t f3,
                          input logic [31:0] imm, input logic [31:0] pc,
                          input logic [31:0] rs1, input logic [31:0] rs2,
                          input logic [31:0] csr);
    issue_t       i;
    exec_result_t e;
    i = '{opcode: opcode, funct3: f3, imm: imm, pc: pc, rs1_value: rs1,
          rs2_value: rs2, csr_rdata: csr};
    e = model_result(i);
    stim_q.push_back(i);
    expect_q.push_back(e);
    care_q.push_back(care_mask(e));
    name_q.push_back(name);
  endtask

  task automatic build_table();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    funct3_t     f3;
    add_item("add", opc_op, 3'd0, 32'h0, 32'h0, 32'd5, 32'd7, 32'h0);
    add_item("sub", opc_op, 3'd0, 32'h20, 32'h0, 32'd5, 32'd7, 32'h0);
    add_item("addi", opc_op_imm, 3'd0, 32'hffff_fffd, 32'h0, 32'd10, 32'h0, 32'h0);
    add_item("slt", opc_op, 3'd2, 32'h0, 32'h0, 32'hffff_ffff, 32'd1, 32'h0);
    add_item("sltu", opc_op, 3'd3, 32'h0, 32'h0, 32'hffff_ffff, 32'd1, 32'h0);
    add_item("slti", opc_op_imm, 3'd2, 32'd5, 32'h0, 32'hffff_fff9, 32'h0, 32'h0);
    add_item("sll", opc_op, 3'd1, 32'h0, 32'h0, 32'd1, 32'd31, 32'h0);
    add_item("srl", opc_op, 3'd5, 32'h0, 32'h0, 32'h8000_0000, 32'd4, 32'h0);
    add_item("sra", opc_op, 3'd5, 32'h20, 32'h0, 32'h8000_0000, 32'd4, 32'h0);
    add_item("srli", opc_op_imm, 3'd5, 32'd8, 32'h0, 32'h8000_0000, 32'h0, 32'h0);
    add_item("srai", opc_op_imm, 3'd5, 32'h408, 32'h0, 32'h8000_0000, 32'h0, 32'h0);
    add_item("xor", opc_op, 3'd4, 32'h0, 32'h0, 32'hf0f0_1234, 32'h0ff0_ffff, 32'h0);
    add_item("or", opc_op, 3'd6, 32'h0, 32'h0, 32'hf0f0_0000, 32'h0000_0f0f, 32'h0);
    add_item("andi", opc_op_imm, 3'd7, 32'hffff_ff0f, 32'h0, 32'h1234_5678, 32'h0, 32'h0);
    add_item("lui", opc_lui, 3'd0, 32'h1234_5000, 32'h0, 32'hdead_beef, 32'h0, 32'h0);
    add_item("auipc", opc_auipc, 3'd0, 32'h0000_2000, 32'h1000, 32'h0, 32'h0, 32'h0);
    add_item("lw", opc_load, 3'd2, 32'd16, 32'h0, 32'h100, 32'h0, 32'h0);
    add_item("lb", opc_load, 3'd0, 32'hffff_fffc, 32'h0, 32'h100, 32'h0, 32'h0);
    add_item("lhu", opc_load, 3'd5, 32'd2, 32'h0, 32'h200, 32'h0, 32'h0);
    add_item("sb", opc_store, 3'd0, 32'd3, 32'h0, 32'h400, 32'h0000_00a5, 32'h0);
    add_item("sh", opc_store, 3'd1, 32'd6, 32'h0, 32'h400, 32'h0000_beef, 32'h0);
    add_item("sw", opc_store, 3'd2, 32'd8, 32'h0, 32'h400, 32'hcafe_f00d, 32'h0);
    add_item("jal", opc_jal, 3'd0, 32'h40, 32'h200, 32'h0, 32'h0, 32'h0);
    add_item("jalr", opc_jalr, 3'd0, 32'd4, 32'h200, 32'h301, 32'h0, 32'h0); // odd sum
    add_item("beq_taken", opc_branch, 3'd0, 32'h10, 32'h300, 32'd9, 32'd9, 32'h0);
    add_item("beq_not", opc_branch, 3'd0, 32'h10, 32'h300, 32'd9, 32'd8, 32'h0);
    add_item("bne", opc_branch, 3'd1, 32'hffff_fff0, 32'h300, 32'd9, 32'd8, 32'h0);
    add_item("blt", opc_branch, 3'd4, 32'h20, 32'h300, 32'hffff_ffff, 32'd1, 32'h0);
    add_item("bge", opc_branch, 3'd5, 32'h20, 32'h300, 32'hffff_ffff, 32'd1, 32'h0);
    add_item("bltu", opc_branch, 3'd6, 32'h20, 32'h300, 32'hffff_ffff, 32'd1, 32'h0);
    add_item("bgeu", opc_branch, 3'd7, 32'h20, 32'h300, 32'hffff_ffff, 32'd1, 32'h0);
    add_item("csrrw", opc_system, 3'd1, 32'h300, 32'h0, 32'h0000_00aa, 32'h0, 32'h55);
    add_item("csrrs", opc_system, 3'd2, 32'h300, 32'h0, 32'h0000_00aa, 32'h0, 32'h55);
    add_item("ecall", opc_system, 3'd0, 32'h0, 32'h500, 32'h0, 32'h0, 32'h80);
    add_item("ebreak", opc_system, 3'd0, 32'h1, 32'h500, 32'h0, 32'h0, 32'h80);
    add_item("mret", opc_system, 3'd0, 32'h302, 32'h80, 32'h0, 32'h0, 32'h504);
    add_item("fence_i", opc_misc_mem, 3'd1, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0);
    for (int n = 0; n < 16; n++) begin
      a   = $urandom;
      b   = $urandom;
      f3  = b[15:13];
      imm = {{20{b[11]}}, b[11:0]};   // sign-extended 12-bit immediate
      case (n % 4)
        0: add_item($sformatf("rand_op_%0d", n), opc_op, f3,
                    (f3 == 3'd0 || f3 == 3'd5) ? {26'd0, b[12], 5'd0} : 32'h0,
                    32'h0, a, $urandom, 32'h0);
        1: add_item($sformatf("rand_opimm_%0d", n), opc_op_imm, f3,
                    (f3 == 3'd1) ? {27'd0, b[4:0]} :
                    (f3 == 3'd5) ? {21'd0, b[12], 5'd0, b[4:0]} : imm,
                    32'h0, a, 32'h0, 32'h0);
        2: begin
          if (f3[2:1] == 2'b01) f3[2] = 1'b1;   // no branch on funct3 2, 3
          add_item($sformatf("rand_branch_%0d", n), opc_branch, f3, {imm[31:1], 1'b0},
                   {b[31:16], 16'h0}, a, b[0] ? a : $urandom, 32'h0);
        end
        default: add_item($sformatf("rand_load_%0d", n), opc_load, f3, imm, 32'h0,
                          a, 32'h0, 32'h0);
      endcase
    end
    num_items = stim_q.size();
  endtask

  initial begin
    decode_valid = 1'b0;
    issue        = '0;
    reset        = 1'b1;
    void'($urandom(19935));
    build_table();
    repeat (reset_cycles) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    repeat (3) begin                     // nothing issued yet
      @(negedge clock);
      check_valid("after_reset", 1'b0, result_valid);
      check_result("after_reset", '0, '1, result);
    end
    for (int k = 0; k < num_items + 2; k++) begin
      @(negedge clock);
      if (k >= 2) begin                  // row issued two cycles ago
        check_valid(name_q[k - 2], 1'b1, result_valid);
        check_result(name_q[k - 2], expect_q[k - 2], care_q[k - 2], result);
      end else begin
        check_valid("pipe_fill", 1'b0, result_valid);
      end
      if (k < num_items) begin
        decode_valid = 1'b1;
        issue        = stim_q[k];
      end else begin
        decode_valid = 1'b0;
        issue        = '0;
      end
    end
    @(negedge clock);
    check_valid("drain", 1'b0, result_valid);
    $display("TESTS PASSED");
    $finish;
  end

  always @(exec_top_inst.exec_asserts_inst.failures) begin
    if (exec_top_inst.exec_asserts_inst.failures != 0) begin
      stop_on_error("a concurrent assertion in exec_asserts failed");
    end
  end

  // watchdog sized from the table
  initial begin
    wait (num_items > 0);
    repeat (reset_cycles + num_items + 20) @(posedge clock);
    stop_on_error("watchdog timeout, the run did not reach its end");
  end

endmodule

`default_nettype wire

// File: files.f
hw/rv_isa_pkg.sv
hw/exec_ctrl_pkg.sv
hw/stage_reg.sv
hw/exec_ctrl_decode.sv
hw/exec_unit.sv
hw/result_stage.sv
hw/exec_top.sv
testbench/exec_asserts.sv
testbench/exec_tb.sv

// File: Bender.yml
package:
  name: exec_slice

sources:
  - hw/rv_isa_pkg.sv
  - hw/exec_ctrl_pkg.sv
  - hw/stage_reg.sv
  - hw/exec_ctrl_decode.sv
  - hw/exec_unit.sv
  - hw/result_stage.sv
  - hw/exec_top.sv
  - target: test
    files:
      - testbench/exec_asserts.sv
      - testbench/exec_tb.sv
